// ==== Makefile ====
# Verilator build for the bit-scan unit and its testbench

LOG := sim.log

.PHONY: all lint sim clean

all: sim

# Lint the design on its own, then with the testbench
lint:
	verilator --lint-only --timing --timescale 1ns/10ps -f tb.f --top-module bitscan_top
	verilator --lint-only --timing --timescale 1ns/10ps -f tb.f --top-module tb_bitscan

# Build, run, and decide pass or fail from the log
sim:
	verilator --binary --timing --timescale 1ns/10ps -f tb.f \
		--top-module tb_bitscan -o Vtb_bitscan
	./obj_dir/Vtb_bitscan | tee $(LOG)
	@if grep -q "^TEST OK$$" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

// ==== bitscan_cond.sv ====
// Input stage: request register and scan-vector conditioning
`timescale 1ns/10ps
`include "bitscan_macros.svh"

module bitscan_cond import bitscan_pkg::*; (
  input  logic   clk,
  input  logic   rst_n_i,
  input  logic   valid_i,
  input  bs_op_e op_i,
  input  rd_t    rd_i,
  input  word_t  operand_i,
  scan_if.src    out
);

  word_t rev_operand;
  word_t sign_mask;
  word_t scan_vec;

  ////////////////////////////////////////////////////////////////////////////
  // Scan vector
  ////////////////////////////////////////////////////////////////////////////

  // Mirror the word so the top bit lands on bit 0
  always_comb begin
    for (int b = 0; b < `BS_WORD_W; b++) begin
      rev_operand[b] = operand_i[`BS_WORD_W-1-b];
    end
  end

  // Sign bit copied across the word
  assign sign_mask = {`BS_WORD_W{operand_i[`BS_WORD_W-1]}};

  // Map each op onto a lowest-set-bit search
  // CLB bit 0 cancels to zero, first one is the first bit unlike the sign
  always_comb begin
    case (op_i)
      OP_FL1:  scan_vec = rev_operand;
      OP_CLB:  scan_vec = rev_operand ^ sign_mask;
      default: scan_vec = operand_i;  // FF1 and CNT
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stage register
  ////////////////////////////////////////////////////////////////////////////

  // Strobe, cleared by reset
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      out.valid <= 1'b0;
    end else begin
      out.valid <= valid_i;
    end
  end

  // Payload only moves with a request
  always_ff @(posedge clk) begin
    if (valid_i) begin
      out.op       <= op_i;
      out.rd       <= rd_i;
      out.operand  <= operand_i;
      out.scan_vec <= scan_vec;
    end
  end

endmodule

// ==== bitscan_ff_one.sv ====
// Combinational find-first-one priority tree with zero detect
`timescale 1ns/10ps

module bitscan_ff_one #(
  parameter int LEN = 32
) (
  input  logic [LEN-1:0]         in_i,
  output logic [$clog2(LEN)-1:0] first_one_o,
  output logic                   no_ones_o
);

  // Tree depth, same as the index width
  localparam int LVLS  = $clog2(LEN);
  // Nodes of a full binary tree over the padded length
  localparam int NODES = 2**LVLS - 1;

  // Heap order, node n has children 2n+1 and 2n+2
  logic [NODES-1:0]           any_nodes;
  logic [NODES-1:0][LVLS-1:0] pos_nodes;

  ////////////////////////////////////////////////////////////////////////////
  // Tree levels
  ////////////////////////////////////////////////////////////////////////////

  for (genvar lvl = 0; lvl < LVLS; lvl++) begin : g_lvl
    // First node of this level and of the level below
    localparam int BASE  = 2**lvl - 1;
    localparam int CHILD = 2**(lvl+1) - 1;

    for (genvar n = 0; n < 2**lvl; n++) begin : g_node
      if (lvl < LVLS-1) begin : g_inner
        // Lower child wins whenever it saw a one
        assign any_nodes[BASE+n] = any_nodes[CHILD+2*n] | any_nodes[CHILD+2*n+1];
        assign pos_nodes[BASE+n] = any_nodes[CHILD+2*n] ? pos_nodes[CHILD+2*n]
                                                         : pos_nodes[CHILD+2*n+1];
      end else if (2*n < LEN-1) begin : g_pair
        // Leaf over two neighbouring bits
        assign any_nodes[BASE+n] = in_i[2*n] | in_i[2*n+1];
        assign pos_nodes[BASE+n] = in_i[2*n] ? LVLS'(2*n) : LVLS'(2*n+1);
      end else if (2*n == LEN-1) begin : g_odd
        // Odd length, last bit has no partner
        assign any_nodes[BASE+n] = in_i[2*n];
        assign pos_nodes[BASE+n] = LVLS'(2*n);
      end else begin : g_pad
        // Beyond the vector, never selected
        assign any_nodes[BASE+n] = 1'b0;
        assign pos_nodes[BASE+n] = '0;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Root
  ////////////////////////////////////////////////////////////////////////////

  // Index is don't-care when no_ones_o is high
  assign first_one_o = pos_nodes[0];
  assign no_ones_o   = ~any_nodes[0];

endmodule

// ==== bitscan_fmt.sv ====
// Output stage: architectural result formatting and write-back register
`timescale 1ns/10ps
`include "bitscan_macros.svh"

module bitscan_fmt import bitscan_pkg::*; (
  input  logic  clk,
  input  logic  rst_n_i,
  count_if.dst  in,
  output logic  valid_o,
  output rd_t   rd_o,
  output word_t result_o
);

  // Every result fits in 0..32
  cnt_t res_narrow;

  ////////////////////////////////////////////////////////////////////////////
  // Result select
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (in.op)
      OP_FF1: begin
        // Zero operand reports the word width
        res_narrow = in.no_ones ? cnt_t'(`BS_WORD_W) : cnt_t'(in.index);
      end
      OP_FL1: begin
        // Index was taken on the mirrored word
        res_narrow = in.no_ones ? cnt_t'(`BS_WORD_W)
                                : cnt_t'(`BS_WORD_W - 1) - cnt_t'(in.index);
      end
      OP_CLB: begin
        // No differing bit, operand is all zeros or all ones
        // Pop count tells the two apart
        if (in.no_ones) begin
          res_narrow = (in.pop == '0) ? '0 : cnt_t'(`BS_WORD_W - 1);
        end else begin
          // Bit 0 is the sign itself, not redundant
          res_narrow = cnt_t'(in.index) - cnt_t'(1);
        end
      end
      default: begin
        res_narrow = in.pop;  // CNT
      end
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Write-back register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= in.valid;
    end
  end

  // Zero-extended to a full word
  always_ff @(posedge clk) begin
    if (in.valid) begin
      rd_o     <= in.rd;
      result_o <= word_t'(res_narrow);
    end
  end

endmodule

// ==== bitscan_if.sv ====
// Stage-to-stage buses scan_if and count_if with their modports
`timescale 1ns/10ps

////////////////////////////////////////////////////////////////////////////
// Conditioning to scan
////////////////////////////////////////////////////////////////////////////

interface scan_if import bitscan_pkg::*; ();

  // One-cycle strobe, no handshake
  logic   valid;
  bs_op_e op;
  rd_t    rd;
  // Untouched operand, needed by the population count
  word_t  operand;
  // Operand mapped so every op becomes a find-first-one
  word_t  scan_vec;

  modport src (output valid, output op, output rd, output operand, output scan_vec);
  modport dst (input valid, input op, input rd, input operand, input scan_vec);

endinterface

////////////////////////////////////////////////////////////////////////////
// Scan to result formatting
////////////////////////////////////////////////////////////////////////////

interface count_if import bitscan_pkg::*; ();

  // One-cycle strobe, no handshake
  logic   valid;
  bs_op_e op;
  rd_t    rd;
  // Raw position of the lowest set bit of the scan vector
  idx_t   index;
  // Scan vector was all zero
  logic   no_ones;
  // Ones in the original operand
  cnt_t   pop;

  modport src (output valid, output op, output rd, output index, output no_ones,
               output pop);
  modport dst (input valid, input op, input rd, input index, input no_ones,
               input pop);

endinterface

// ==== bitscan_macros.svh ====
// Width and latency constants for the bit-scan unit
`ifndef BITSCAN_MACROS_SVH
`define BITSCAN_MACROS_SVH

////////////////////////////////////////////////////////////////////////////
// Datapath sizes
////////////////////////////////////////////////////////////////////////////

// Operand and result width
`define BS_WORD_W 32

// Destination register address width, 32 architectural registers
`define BS_RD_W 5

////////////////////////////////////////////////////////////////////////////
// Pipeline
////////////////////////////////////////////////////////////////////////////

// Cycles from valid_i sampled to valid_o high
// One each for cond, scan and fmt
`define BS_LATENCY 3

`endif

// ==== bitscan_pkg.sv ====
// Shared vector typedefs and operation encoding for the bit-scan unit
`include "bitscan_macros.svh"

package bitscan_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Vector types
  ////////////////////////////////////////////////////////////////////////////

  // One operand or one result
  typedef logic [`BS_WORD_W-1:0] word_t;

  // Bit position inside a word
  typedef logic [$clog2(`BS_WORD_W)-1:0] idx_t;

  // Count of bits, one wider than the index so 32 fits
  typedef logic [$clog2(`BS_WORD_W):0] cnt_t;

  // Write-back register address
  typedef logic [`BS_RD_W-1:0] rd_t;

  ////////////////////////////////////////////////////////////////////////////
  // Operation code
  ////////////////////////////////////////////////////////////////////////////

  // Encoding follows the 2-bit field of the request
  typedef enum logic [1:0] {
    OP_FF1 = 2'b00,  // find first one, from bit 0 up
    OP_FL1 = 2'b01,  // find last one, from bit 31 down
    OP_CLB = 2'b10,  // leading redundant sign bits
    OP_CNT = 2'b11   // population count
  } bs_op_e;

endpackage

// ==== bitscan_scan.sv ====
// Processing stage: priority tree and adder-tree population count, registered
`timescale 1ns/10ps
`include "bitscan_macros.svh"

module bitscan_scan import bitscan_pkg::*; (
  input  logic clk,
  input  logic rst_n_i,
  scan_if.dst  in,
  count_if.src out
);

  // Heap of partial sums, leaves start at BS_WORD_W-1
  localparam int POP_NODES = 2*`BS_WORD_W - 1;

  idx_t first_one;
  logic no_ones;
  cnt_t pop_nodes [POP_NODES];

  ////////////////////////////////////////////////////////////////////////////
  // Priority tree
  ////////////////////////////////////////////////////////////////////////////

  bitscan_ff_one #(
    .LEN (`BS_WORD_W)
  ) u_ff_one (
    .in_i        (in.scan_vec),
    .first_one_o (first_one),
    .no_ones_o   (no_ones)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Population count
  ////////////////////////////////////////////////////////////////////////////

  // Leaves hold one operand bit each
  // Inner nodes add their two children, walked top index down
  always_comb begin
    for (int i = 0; i < `BS_WORD_W; i++) begin
      pop_nodes[`BS_WORD_W-1+i] = cnt_t'(in.operand[i]);
    end
    for (int n = `BS_WORD_W-2; n >= 0; n--) begin
      pop_nodes[n] = pop_nodes[2*n+1] + pop_nodes[2*n+2];
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stage register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      out.valid <= 1'b0;
    end else begin
      out.valid <= in.valid;
    end
  end

  // Raw fields, interpreted by the format stage
  always_ff @(posedge clk) begin
    if (in.valid) begin
      out.op      <= in.op;
      out.rd      <= in.rd;
      out.index   <= first_one;
      out.no_ones <= no_ones;
      out.pop     <= pop_nodes[0];  // root of the sum tree
    end
  end

endmodule

// ==== bitscan_top.sv ====
// Top level of the bit-scan unit, three registered stages
`timescale 1ns/10ps

module bitscan_top import bitscan_pkg::*; (
  input  logic   clk,
  input  logic   rst_n_i,
  // Request, one per cycle at most
  input  logic   valid_i,
  input  bs_op_e op_i,
  input  rd_t    rd_i,
  input  word_t  operand_i,
  // Write-back, three cycles after the request
  output logic   valid_o,
  output rd_t    rd_o,
  output word_t  result_o
);

  ////////////////////////////////////////////////////////////////////////////
  // Stage buses
  ////////////////////////////////////////////////////////////////////////////

  scan_if  scan_bus ();
  count_if count_bus ();

  ////////////////////////////////////////////////////////////////////////////
  // Pipeline
  ////////////////////////////////////////////////////////////////////////////

  // Cycle 1, conditioning
  bitscan_cond u_cond (
    .clk       (clk),
    .rst_n_i   (rst_n_i),
    .valid_i   (valid_i),
    .op_i      (op_i),
    .rd_i      (rd_i),
    .operand_i (operand_i),
    .out       (scan_bus.src)
  );

  // Cycle 2, tree and count
  bitscan_scan u_scan (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .in      (scan_bus.dst),
    .out     (count_bus.src)
  );

  // Cycle 3, formatting
  bitscan_fmt u_fmt (
    .clk      (clk),
    .rst_n_i  (rst_n_i),
    .in       (count_bus.dst),
    .valid_o  (valid_o),
    .rd_o     (rd_o),
    .result_o (result_o)
  );

endmodule

// ==== tb.f ====
+incdir+.
bitscan_pkg.sv
bitscan_if.sv
bitscan_ff_one.sv
bitscan_cond.sv
bitscan_scan.sv
bitscan_fmt.sv
bitscan_top.sv
tb_clk_gen.sv
tb_bitscan.sv

// ==== tb_bitscan.sv ====
// Testbench for the bit-scan unit with stimulus, reference model, scoreboard and timeout
`timescale 1ns/10ps
`include "bitscan_macros.svh"

module tb_bitscan import bitscan_pkg::*; ();

  // Each corner word goes once through every operation
  localparam int N_CORNER   = 14;
  localparam int N_DIRECTED = N_CORNER * 4;
  localparam int N_RANDOM   = 400;
  localparam int N_TOTAL    = N_DIRECTED + N_RANDOM;
  // Random phase idles about a quarter of the slots
  localparam int CYCLE_LIMIT = N_TOTAL * 2 + `BS_LATENCY + 50;

  logic   clk;
  logic   rst_n;
  logic   valid_i;
  bs_op_e op_i;
  rd_t    rd_i;
  word_t  operand_i;
  logic   valid_o;
  rd_t    rd_o;
  word_t  result_o;

  // Scoreboard holds one entry per accepted request
  rd_t   exp_rd_q [$];
  word_t exp_res_q [$];
  int    exp_edge_q [$];

  word_t corner_words [N_CORNER];
  int    edges = 0;
  int    n_checked;
  int    value_errs;
  int    other_errs;

  tb_clk_gen #(
    .PERIOD_NS  (100),
    .RST_CYCLES (3)
  ) u_clk_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  bitscan_top DUT (
    .clk       (clk),
    .rst_n_i   (rst_n),
    .valid_i   (valid_i),
    .op_i      (op_i),
    .rd_i      (rd_i),
    .operand_i (operand_i),
    .valid_o   (valid_o),
    .rd_o      (rd_o),
    .result_o  (result_o)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Reference model built from the operation rules
  ////////////////////////////////////////////////////////////////////////////

  function automatic word_t expected_result(input bs_op_e op, input word_t a);
    int   n;
    logic same;
    n = 0;
    case (op)
      OP_FF1: begin
        // Walk down so the lowest set bit is kept
        n = `BS_WORD_W;
        for (int b = `BS_WORD_W - 1; b >= 0; b--) begin
          if (a[b]) n = b;
        end
      end
      OP_FL1: begin
        // Walk up so the highest set bit is kept
        n = `BS_WORD_W;
        for (int b = 0; b < `BS_WORD_W; b++) begin
          if (a[b]) n = b;
        end
      end
      OP_CLB: begin
        if (a == '0) begin
          n = 0;
        end else if (a == '1) begin
          n = `BS_WORD_W - 1;
        end else begin
          // Bits below the sign that still copy it
          same = 1'b1;
          for (int b = `BS_WORD_W - 2; b >= 0; b--) begin
            if (same && a[b] == a[`BS_WORD_W-1]) n++;
            else same = 1'b0;
          end
        end
      end
      default: begin
        for (int b = 0; b < `BS_WORD_W; b++) begin
          if (a[b]) n++;
        end
      end
    endcase
    return word_t'(n);
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Request capture and cycle limit
  ////////////////////////////////////////////////////////////////////////////

  // Stamp is the count of rising edges before the sampling one
  always @(posedge clk) begin
    edges <= edges + 1;
    if (rst_n && valid_i) begin
      exp_rd_q.push_back(rd_i);
      exp_res_q.push_back(expected_result(op_i, operand_i));
      exp_edge_q.push_back(edges);
    end
    if (edges >= CYCLE_LIMIT) begin
      $display("Timeout: run passed %0d cycles, %0d results still outstanding",
               CYCLE_LIMIT, exp_rd_q.size());
      $display("TEST FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Result compare with outputs sampled mid-cycle
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge clk) begin : compare_results
    rd_t   exp_rd;
    word_t exp_res;
    int    exp_edge;
    if (!rst_n) begin
      if (edges > 0 && valid_o !== 1'b0) begin
        $display("%0t: valid_o is not low during reset", $time);
        other_errs++;
      end
    end else if (valid_o === 1'b1) begin
      if (exp_rd_q.size() == 0) begin
        $display("%0t: valid_o high with no request outstanding", $time);
        other_errs++;
      end else begin
        exp_rd   = exp_rd_q.pop_front();
        exp_res  = exp_res_q.pop_front();
        exp_edge = exp_edge_q.pop_front();
        n_checked++;
        if (edges != exp_edge + `BS_LATENCY) begin
          $display("%0t: result came %0d cycles after its request, not %0d",
                   $time, edges - exp_edge, `BS_LATENCY);
          other_errs++;
        end
        if (rd_o !== exp_rd) begin
          $display("** Error at %0t: rd_o expected %0d, actual %0d", $time, exp_rd, rd_o);
          value_errs++;
        end
        if (result_o !== exp_res) begin
          $display("** Error at %0t: result_o expected %0d, actual %0d",
                   $time, exp_res, result_o);
          value_errs++;
        end
      end
    end else if (valid_o !== 1'b0) begin
      $display("%0t: valid_o is unknown after reset", $time);
      other_errs++;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  task automatic send_request(input bs_op_e op, input rd_t rd, input word_t word);
    @(negedge clk);
    valid_i   = 1'b1;
    op_i      = op;
    rd_i      = rd;
    operand_i = word;
  endtask

  // Idle slot with a moving operand
  task automatic drive_idle();
    @(negedge clk);
    valid_i   = 1'b0;
    operand_i = $urandom;
  endtask

  initial begin : stimulus
    int         sent;
    logic [1:0] op_bits;
    word_t      word;
    valid_i    = 1'b0;
    op_i       = OP_FF1;
    rd_i       = '0;
    operand_i  = '0;
    n_checked  = 0;
    value_errs = 0;
    other_errs = 0;
    sent       = 0;
    void'($urandom(32'hebeb3efb));

    // Single bits, sign edges, patterns and mixed words
    corner_words = '{32'h0000_0000, 32'hffff_ffff, 32'h0000_0001, 32'h0000_0002,
                     32'h0000_8000, 32'h4000_0000, 32'h8000_0000, 32'h7fff_ffff,
                     32'haaaa_aaaa, 32'h5555_5555, 32'h00f0_0f00, 32'h1234_5678,
                     32'hffff_0001, 32'h0001_8000};

    @(posedge rst_n);
    // Quiet stretch where nothing may come out
    repeat (4) drive_idle();

    // Directed requests back to back over every op and corner
    for (int o = 0; o < 4; o++) begin
      for (int c = 0; c < N_CORNER; c++) begin
        send_request(bs_op_e'(2'(o)), rd_t'(c + o), corner_words[c]);
      end
    end
    drive_idle();

    // Random ops with idle gaps
    while (sent < N_RANDOM) begin
      if ($urandom_range(99, 0) < 75) begin
        op_bits = 2'($urandom_range(3, 0));
        word    = $urandom;
        // Sometimes stretch the sign run for larger clb values
        if ($urandom_range(3, 0) == 0) begin
          word = word_t'($signed(word) >>> $urandom_range(31, 0));
        end
        send_request(bs_op_e'(op_bits), rd_t'($urandom_range(31, 0)), word);
        sent++;
      end else begin
        drive_idle();
      end
    end
    drive_idle();

    // Let the last results drain out
    repeat (`BS_LATENCY + 2) @(negedge clk);
    if (exp_rd_q.size() != 0) begin
      $display("%0d requests never produced a result", exp_rd_q.size());
      other_errs++;
    end

    $display("Checked %0d of %0d results: %0d value errors, %0d other errors",
             n_checked, N_TOTAL, value_errs, other_errs);
    if (value_errs == 0 && other_errs == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== tb_clk_gen.sv ====
// Testbench clock and synchronous reset source
`timescale 1ns/10ps

module tb_clk_gen #(
  parameter int PERIOD_NS  = 100,
  parameter int RST_CYCLES = 3
) (
  output logic clk_o,
  output logic rst_n_o
);

  // Free-running clock, low at time zero
  initial begin
    clk_o = 1'b0;
    forever begin
      #(PERIOD_NS/2) clk_o = ~clk_o;
    end
  end

  // Reset held over the first rising edges
  // Released on a falling edge so the DUT sees a clean level
  initial begin
    rst_n_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule
